/* core_controller.sv */
`timescale 1ns/1ps

module core_controller (
  input  logic                  clk,
  input  logic                  rst_n,

  // core enable and status
  input  logic                  fetch_enable_i,
  output logic                  ctrl_busy_o,
  output logic                  first_fetch_o,
  output logic                  is_decoding_o,
  output logic                  deassert_we_o,

  // decoder flags
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  pipe_flush_i,
  input  logic                  ebrk_insn_i,
  input  logic                  csr_status_i,

  // lsu
  input  logic                  lsu_load_err_i,
  input  logic                  lsu_store_err_i,
  input  logic                  load_stall_i,

  // if/id pipeline and prefetcher
  input  logic                  instr_valid_i,
  input  logic                  id_ready_i,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_sel_t     pc_mux_o,
  output ctrl_pkg::exc_pc_sel_t exc_pc_mux_o,

  // branches and jumps
  input  logic                  branch_in_id_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  instr_multicycle_i,

  // interrupt controller
  input  logic                  irq_req_ctrl_i,
  input  ctrl_pkg::irq_id_t     irq_id_ctrl_i,
  input  logic                  m_ie_i,
  output logic                  irq_ack_o,
  output ctrl_pkg::irq_id_t     irq_id_o,

  // exception and csr
  output ctrl_pkg::exc_cause_t  exc_cause_o,
  output logic                  exc_ack_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output ctrl_pkg::exc_cause_t  csr_cause_o,
  output logic                  csr_restore_mret_id_o,
  output logic                  csr_save_cause_o,

  // stalls
  output logic                  halt_if_o,
  output logic                  halt_id_o
);

  import ctrl_pkg::*;

  ctrl_state_t ctrl_state;
  logic        flush_pending;
  logic        load_fault_req;
  logic        store_fault_req;
  logic        load_fault_ack;
  logic        store_fault_ack;

  // acked id is the requested one
  assign irq_id_o = irq_id_ctrl_i;

  ////////////////////
  // fault tracker
  ////////////////////

  lsu_fault_tracker u_fault (
    .clk               (clk),
    .rst_n             (rst_n),
    .lsu_load_err_i    (lsu_load_err_i),
    .lsu_store_err_i   (lsu_store_err_i),
    .load_stall_i      (load_stall_i),
    .load_fault_ack_i  (load_fault_ack),
    .store_fault_ack_i (store_fault_ack),
    .load_fault_req_o  (load_fault_req),
    .store_fault_req_o (store_fault_req)
  );

  ////////////////////
  // controller fsm
  ////////////////////

  ctrl_fsm u_fsm (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .instr_valid_i      (instr_valid_i),
    .id_ready_i         (id_ready_i),
    .instr_multicycle_i (instr_multicycle_i),
    .branch_in_id_i     (branch_in_id_i),
    .illegal_insn_i     (illegal_insn_i),
    .flush_pending_i    (flush_pending),
    .irq_req_ctrl_i     (irq_req_ctrl_i),
    .m_ie_i             (m_ie_i),
    .ctrl_state_o       (ctrl_state),
    .instr_req_o        (instr_req_o),
    .ctrl_busy_o        (ctrl_busy_o),
    .first_fetch_o      (first_fetch_o),
    .is_decoding_o      (is_decoding_o),
    .halt_if_o          (halt_if_o),
    .halt_id_o          (halt_id_o),
    .irq_ack_o          (irq_ack_o),
    .exc_ack_o          (exc_ack_o),
    .deassert_we_o      (deassert_we_o)
  );

  ////////////////////
  // pc and cause
  ////////////////////

  pc_cause_encoder u_enc (
    .ctrl_state_i          (ctrl_state),
    .instr_valid_i         (instr_valid_i),
    .branch_set_i          (branch_set_i),
    .jump_set_i            (jump_set_i),
    .ecall_insn_i          (ecall_insn_i),
    .illegal_insn_i        (illegal_insn_i),
    .mret_insn_i           (mret_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .csr_status_i          (csr_status_i),
    .pipe_flush_i          (pipe_flush_i),
    .load_fault_req_i      (load_fault_req),
    .store_fault_req_i     (store_fault_req),
    .irq_id_i              (irq_id_ctrl_i),
    .flush_pending_o       (flush_pending),
    .pc_set_o              (pc_set_o),
    .pc_mux_o              (pc_mux_o),
    .exc_pc_mux_o          (exc_pc_mux_o),
    .exc_cause_o           (exc_cause_o),
    .csr_cause_o           (csr_cause_o),
    .csr_save_if_o         (csr_save_if_o),
    .csr_save_id_o         (csr_save_id_o),
    .csr_save_cause_o      (csr_save_cause_o),
    .csr_restore_mret_id_o (csr_restore_mret_id_o),
    .load_fault_ack_o      (load_fault_ack),
    .store_fault_ack_o     (store_fault_ack)
  );

endmodule

/* core_controller_props.sv */
`timescale 1ns/1ps

module core_controller_props (
  input logic                  clk,
  input logic                  rst_n,
  input ctrl_pkg::ctrl_state_t ctrl_state_i,
  input logic                  fetch_enable_i,
  input logic                  irq_req_i,
  input logic                  m_ie_i,
  input logic                  instr_req_i,
  input logic                  irq_ack_i,
  input logic                  exc_ack_i
);

  import ctrl_pkg::*;

  // failures seen so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // flush state never repeats back to back
  a_flush_one: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_state_i == FLUSH |=> ctrl_state_i != FLUSH)
    else begin
      $error("FLUSH state held for more than one cycle");
      fail_cnt++;
    end

  // interrupt entry is a single cycle too
  a_irq_one: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_state_i == IRQ_TAKEN |=> ctrl_state_i != IRQ_TAKEN)
    else begin
      $error("IRQ_TAKEN state held for more than one cycle");
      fail_cnt++;
    end

  // both acks come together and only after an enabled request
  a_ack_pair: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_i |-> exc_ack_i && $past(irq_req_i && m_ie_i))
    else begin
      $error("irq_ack_o without exc_ack_o or without an enabled request");
      fail_cnt++;
    end

  // no fetch request follows reset until the core is enabled
  a_req_reset: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_state_i == RESET && !fetch_enable_i |=> !instr_req_i)
    else begin
      $error("instr_req_o high after RESET without fetch_enable_i");
      fail_cnt++;
    end

endmodule

bind ctrl_fsm core_controller_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .ctrl_state_i   (ctrl_state_o),
  .fetch_enable_i (fetch_enable_i),
  .irq_req_i      (irq_req_ctrl_i),
  .m_ie_i         (m_ie_i),
  .instr_req_i    (instr_req_o),
  .irq_ack_i      (irq_ack_o),
  .exc_ack_i      (exc_ack_o)
);

/* core_controller_tb.sv */
`timescale 1ns/1ps

module core_controller_tb;

  import ctrl_pkg::*;

  // expected fields of one pc redirect
  typedef struct packed {
    logic        pc_set;
    pc_sel_t     pc_mux;
    exc_pc_sel_t exc_pc;
    exc_cause_t  exc_cause;
    exc_cause_t  csr_cause;
    logic        save_if;
    logic        save_id;
    logic        save_cause;
    logic        restore;
  } exp_t;

  logic clk;
  logic rst_n;

  // dut inputs
  logic fetch_enable_i, illegal_insn_i, ecall_insn_i, mret_insn_i;
  logic pipe_flush_i, ebrk_insn_i, csr_status_i;
  logic lsu_load_err_i, lsu_store_err_i, load_stall_i;
  logic instr_valid_i, id_ready_i, branch_in_id_i, branch_set_i;
  logic jump_set_i, instr_multicycle_i, irq_req_ctrl_i, m_ie_i;
  irq_id_t irq_id_ctrl_i;

  // dut outputs
  logic ctrl_busy_o, first_fetch_o, is_decoding_o, deassert_we_o;
  logic instr_req_o, pc_set_o, irq_ack_o, exc_ack_o, halt_if_o, halt_id_o;
  logic csr_save_if_o, csr_save_id_o, csr_restore_mret_id_o, csr_save_cause_o;
  pc_sel_t     pc_mux_o;
  exc_pc_sel_t exc_pc_mux_o;
  irq_id_t     irq_id_o;
  exc_cause_t  exc_cause_o, csr_cause_o;

  // expectation shared between stimulus and compare
  exp_t        exp_cur;
  logic        exp_armed = 1'b0;
  logic        exp_irq = 1'b0;
  irq_id_t     exp_irq_id = '0;
  int          event_cnt = 0;
  int          err_cnt = 0;
  int          err_base = 0;
  int          check_cnt = 0;
  int          tests_run = 0;
  logic [31:0] lfsr_q = 32'h36cb_7041;
  // rough cycle budget per test in the order boot, jump, flush, fault, irq
  int          test_cycles [5] = '{30, 16, 96, 48, 64};

  tb_clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  core_controller UUT (.*);

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic exp_t exception_entry(input exc_pc_sel_t vec, input exc_cause_t cause);
    exp_t e;
    e            = '0;
    e.pc_set     = 1'b1;
    e.pc_mux     = PC_EXCEPTION;
    e.exc_pc     = vec;
    e.exc_cause  = cause;
    e.csr_cause  = cause;
    e.save_id    = 1'b1;
    e.save_cause = 1'b1;
    return e;
  endfunction

  // flag bits 0 ecall 1 illegal 2 mret 3 ebreak 4 csr status 5 pipe flush
  // 6 load fault 7 store fault, lowest index has priority
  function automatic exp_t expected_flush(input logic [7:0] flags);
    exp_t e;
    int   first;
    e     = '0;
    first = 8;
    for (int i = 7; i >= 0; i--) begin
      if (flags[i]) first = i;
    end
    case (first)
      0: e = exception_entry(EXC_PC_ECALL, EXC_CAUSE_ECALL_MMODE);
      1: e = exception_entry(EXC_PC_ILLINSN, EXC_CAUSE_ILLEGAL_INSN);
      2: begin
        e.pc_set  = 1'b1;
        e.pc_mux  = PC_ERET;
        e.restore = 1'b1;
      end
      // ebreak keeps the pc and only reports its cause
      3: e.exc_cause = EXC_CAUSE_BREAKPOINT;
      6: e = exception_entry(EXC_PC_LOAD, EXC_CAUSE_LOAD_FAULT);
      7: e = exception_entry(EXC_PC_STORE, EXC_CAUSE_STORE_FAULT);
      // csr status and pipe flush keep the pc
      default: e.pc_set = 1'b0;
    endcase
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("Error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // bounded wait on negedges for the event counter
  task automatic wait_events(input int target, input string what);
    int cycles;
    cycles = 0;
    while (event_cnt < target && cycles < 30) begin
      @(negedge clk);
      cycles++;
    end
    assert (event_cnt >= target) else begin
      $display("timeout: no %s redirect seen within 30 cycles", what);
      err_cnt++;
    end
  endtask

  task automatic apply_flags(input logic [7:0] f);
    ecall_insn_i   = f[0];
    illegal_insn_i = f[1];
    mret_insn_i    = f[2];
    ebrk_insn_i    = f[3];
    csr_status_i   = f[4];
    pipe_flush_i   = f[5];
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %s done with %0d errors", name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  ////////////////////
  // compare
  ////////////////////

  // outputs are sampled at the rising edge and settled since the falling edge
  always @(posedge clk) begin
    if (rst_n && (pc_set_o || irq_ack_o)) begin
      event_cnt++;
      assert (exp_armed) else begin
        $display("unexpected pc redirect or irq ack at %0t ns", $time);
        err_cnt++;
      end
      if (exp_armed) begin
        check_value("pc_set_o", pc_set_o, exp_cur.pc_set);
        check_value("pc_mux_o", pc_mux_o, exp_cur.pc_mux);
        // vector and cause only matter for exceptions
        if (exp_cur.pc_mux == PC_EXCEPTION) begin
          check_value("exc_pc_mux_o", exc_pc_mux_o, exp_cur.exc_pc);
          check_value("exc_cause_o", exc_cause_o, exp_cur.exc_cause);
          check_value("csr_cause_o", csr_cause_o, exp_cur.csr_cause);
        end
        check_value("csr_save_if_o", csr_save_if_o, exp_cur.save_if);
        check_value("csr_save_id_o", csr_save_id_o, exp_cur.save_id);
        check_value("csr_save_cause_o", csr_save_cause_o, exp_cur.save_cause);
        check_value("csr_restore_mret_id_o", csr_restore_mret_id_o, exp_cur.restore);
        check_value("irq_ack_o", irq_ack_o, exp_irq);
        if (exp_irq) begin
          check_value("exc_ack_o", exc_ack_o, 1'b1);
          check_value("irq_id_o", irq_id_o, exp_irq_id);
        end
      end
    end
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial begin : watchdog
    int total;
    total = 0;
    foreach (test_cycles[i]) total += test_cycles[i];
    #(total * 4 + 200);
    $display("timeout: run did not finish within %0d ns", total * 4 + 200);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [7:0]  flags;
    logic [31:0] rnd;
    int          base;
    int          stall_len;
    irq_id_t     id;
    int          total_err;

    fetch_enable_i = 0;
    apply_flags(8'h00);
    lsu_load_err_i = 0;
    lsu_store_err_i = 0;
    load_stall_i = 0;
    instr_valid_i = 0;
    id_ready_i = 0;
    branch_in_id_i = 0;
    branch_set_i = 0;
    jump_set_i = 0;
    instr_multicycle_i = 0;
    irq_req_ctrl_i = 0;
    m_ie_i = 0;
    irq_id_ctrl_i = '0;
    exp_cur = '0;

    wait (rst_n === 1'b1);
    @(negedge clk);

    // boot idles in reset, sets one boot pc, then first fetch until id ready
    repeat (3) begin
      check_value("instr_req_o", instr_req_o, 1'b0);
      check_value("ctrl_busy_o", ctrl_busy_o, 1'b0);
      // nothing is decoded yet so writes stay off
      check_value("deassert_we_o", deassert_we_o, 1'b1);
      @(negedge clk);
    end
    exp_cur        = '0;
    exp_cur.pc_set = 1'b1;
    exp_cur.pc_mux = PC_BOOT;
    exp_armed      = 1'b1;
    fetch_enable_i = 1;
    wait_events(1, "boot");
    repeat (3) begin
      check_value("first_fetch_o", first_fetch_o, 1'b1);
      @(negedge clk);
    end
    id_ready_i    = 1;
    instr_valid_i = 1;
    @(negedge clk);
    check_value("first_fetch_o", first_fetch_o, 1'b0);
    check_value("is_decoding_o", is_decoding_o, 1'b1);
    check_value("boot events", event_cnt, 1);
    report_test("boot");

    // branch then jump give one redirect each in the same cycle
    exp_cur.pc_mux = PC_JUMP;
    for (int k = 0; k < 2; k++) begin
      base         = event_cnt;
      branch_set_i = (k == 0);
      jump_set_i   = (k == 1);
      @(negedge clk);
      branch_set_i = 0;
      jump_set_i   = 0;
      repeat (2) @(negedge clk);
      check_value("jump events", event_cnt, base + 1);
    end
    report_test("jump");

    // random instruction flags held through decode and flush
    repeat (12) begin
      rnd   = take_bits(6);
      flags = {2'b00, rnd[5:0]};
      if (flags == 8'h00) flags[5] = 1'b1;
      exp_cur = expected_flush(flags);
      base    = event_cnt;
      apply_flags(flags);
      // decode cycle with a pending flush freezes if and id
      @(posedge clk);
      check_value("halt_if_o", halt_if_o, 1'b1);
      check_value("halt_id_o", halt_id_o, 1'b1);
      check_value("deassert_we_o", deassert_we_o, flags[1]);
      // in the flush cycle a kept pc still shows its cause
      @(negedge clk);
      if (!exp_cur.pc_set) begin
        check_value("exc_cause_o", exc_cause_o, exp_cur.exc_cause);
      end
      @(negedge clk);
      apply_flags(8'h00);
      repeat (2) @(negedge clk);
      check_value("flush events", event_cnt, base + (exp_cur.pc_set ? 1 : 0));
    end
    report_test("flush");

    // load fault without a stall
    exp_cur        = expected_flush(8'h40);
    base           = event_cnt;
    lsu_load_err_i = 1;
    @(negedge clk);
    lsu_load_err_i = 0;
    wait_events(base + 1, "load fault");
    repeat (3) @(negedge clk);
    check_value("load fault events", event_cnt, base + 1);

    // store fault held behind a random load stall
    rnd             = take_bits(3);
    stall_len       = 3 + rnd[2:0];
    exp_armed       = 1'b0;
    base            = event_cnt;
    lsu_store_err_i = 1;
    load_stall_i    = 1;
    @(negedge clk);
    lsu_store_err_i = 0;
    repeat (stall_len) @(negedge clk);
    check_value("events during stall", event_cnt, base);
    exp_cur      = expected_flush(8'h80);
    exp_armed    = 1'b1;
    load_stall_i = 0;
    wait_events(base + 1, "store fault");
    repeat (3) @(negedge clk);
    check_value("store fault events", event_cnt, base + 1);
    report_test("fault");

    // enabled interrupts with random ids
    exp_cur            = '0;
    exp_cur.pc_set     = 1'b1;
    exp_cur.pc_mux     = PC_EXCEPTION;
    exp_cur.exc_pc     = EXC_PC_IRQ;
    exp_cur.save_if    = 1'b1;
    exp_cur.save_cause = 1'b1;
    exp_irq            = 1'b1;
    repeat (3) begin
      rnd               = take_bits(5);
      id                = rnd[4:0];
      exp_irq_id        = id;
      exp_cur.exc_cause = {1'b0, id};
      exp_cur.csr_cause = {1'b1, id};
      base              = event_cnt;
      irq_id_ctrl_i     = id;
      irq_req_ctrl_i    = 1;
      m_ie_i            = 1;
      wait_events(base + 1, "interrupt");
      irq_req_ctrl_i = 0;
      repeat (2) @(negedge clk);
      check_value("irq events", event_cnt, base + 1);
    end
    // masked request must stay unanswered
    exp_armed      = 1'b0;
    exp_irq        = 1'b0;
    base           = event_cnt;
    m_ie_i         = 0;
    irq_req_ctrl_i = 1;
    repeat (20) @(negedge clk);
    irq_req_ctrl_i = 0;
    check_value("masked irq events", event_cnt, base);
    report_test("irq");

    total_err = err_cnt + UUT.u_fsm.u_props.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, check_cnt, err_cnt, UUT.u_fsm.u_props.fail_cnt);
    if (total_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* ctrl_fsm.sv */
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                  clk,
  input  logic                  rst_n,

  // start of execution, only sampled in reset
  input  logic                  fetch_enable_i,

  // id stage status
  input  logic                  instr_valid_i,
  input  logic                  id_ready_i,
  input  logic                  instr_multicycle_i,
  input  logic                  branch_in_id_i,
  input  logic                  illegal_insn_i,

  // some flush reason holds, from the encoder
  input  logic                  flush_pending_i,

  // interrupt request and machine enable
  input  logic                  irq_req_ctrl_i,
  input  logic                  m_ie_i,

  output ctrl_pkg::ctrl_state_t ctrl_state_o,
  output logic                  instr_req_o,
  output logic                  ctrl_busy_o,
  output logic                  first_fetch_o,
  output logic                  is_decoding_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,
  output logic                  irq_ack_o,
  output logic                  exc_ack_o,
  output logic                  deassert_we_o
);

  import ctrl_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        irq_take;
  logic        irq_ok_decode;

  // interrupt is both requested and enabled
  assign irq_take = irq_req_ctrl_i & m_ie_i;

  // in decode a valid insn must not be multicycle or a branch
  assign irq_ok_decode = irq_take &
                         (~instr_valid_i | (~instr_multicycle_i & ~branch_in_id_i));

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d   = state_q;
    halt_if_o = 1'b0;
    halt_id_o = 1'b0;

    case (state_q)
      // wait for the core to be enabled
      RESET: begin
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // boot pc is set in this cycle by the encoder
      BOOT_SET: begin
        state_d = FIRST_FETCH;
      end

      // stay while the if stage misses
      FIRST_FETCH: begin
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // interrupt overrides the fetch wait
        if (irq_take) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      DECODE: begin
        if (flush_pending_i) begin
          // insn or fault needs a flush, freeze the front end
          state_d   = FLUSH;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end else if (irq_ok_decode) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      // one cycle, reason outputs come from the encoder
      FLUSH: begin
        halt_id_o = 1'b1;
        state_d   = DECODE;
      end

      // one cycle, vector jump and acks
      IRQ_TAKEN: begin
        state_d = DECODE;
      end

      default: begin
        state_d = RESET;
      end
    endcase
  end

  ////////////////////
  // state register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // status outputs
  ////////////////////

  assign ctrl_state_o  = state_q;

  // idle only while waiting in reset
  assign instr_req_o   = (state_q != RESET);
  assign ctrl_busy_o   = (state_q != RESET);
  assign first_fetch_o = (state_q == FIRST_FETCH);
  assign is_decoding_o = (state_q == DECODE) & instr_valid_i;

  // interrupt taken, both acks together
  assign irq_ack_o     = (state_q == IRQ_TAKEN);
  assign exc_ack_o     = (state_q == IRQ_TAKEN);

  // no register write unless a legal insn is decoded
  assign deassert_we_o = ~is_decoding_o | illegal_insn_i;

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

  ////////////////////
  // widths
  ////////////////////

  // interrupt line number and cause code widths
  localparam int IRQ_ID_W    = 5;
  localparam int EXC_CAUSE_W = 6;

  typedef logic [IRQ_ID_W-1:0]    irq_id_t;
  typedef logic [EXC_CAUSE_W-1:0] exc_cause_t;

  ////////////////////
  // state machines
  ////////////////////

  // main controller states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_t;

  // per-fault tracker state
  // held means seen during a load stall, req means raised to the controller
  typedef enum logic [1:0] {
    FAULT_IDLE,
    FAULT_HELD,
    FAULT_REQ
  } fault_st_t;

  ////////////////////
  // pc selects
  ////////////////////

  // fetch stage pc source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXCEPTION,
    PC_ERET
  } pc_sel_t;

  // exception vector select, five targets
  typedef enum logic [2:0] {
    EXC_PC_IRQ,
    EXC_PC_ILLINSN,
    EXC_PC_ECALL,
    EXC_PC_LOAD,
    EXC_PC_STORE
  } exc_pc_sel_t;

  ////////////////////
  // cause codes
  ////////////////////

  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN = 6'd2;
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT   = 6'd3;
  localparam exc_cause_t EXC_CAUSE_LOAD_FAULT   = 6'd5;
  localparam exc_cause_t EXC_CAUSE_STORE_FAULT  = 6'd7;
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE  = 6'd11;

endpackage

/* lsu_fault_tracker.sv */
`timescale 1ns/1ps

module lsu_fault_tracker (
  input  logic clk,
  input  logic rst_n,

  // error strobes from the lsu
  input  logic lsu_load_err_i,
  input  logic lsu_store_err_i,
  input  logic load_stall_i,

  // acknowledges from the encoder, one cycle each
  input  logic load_fault_ack_i,
  input  logic store_fault_ack_i,

  // pending exception requests
  output logic load_fault_req_o,
  output logic store_fault_req_o
);

  import ctrl_pkg::*;

  // index 0 is the load fault, index 1 the store fault
  logic [1:0] err_q;
  logic [1:0] ack;
  logic [1:0] req;
  fault_st_t  st_q [2];
  fault_st_t  st_d [2];

  assign ack = {store_fault_ack_i, load_fault_ack_i};

  ////////////////////
  // strobe register
  ////////////////////

  // error strobes are taken one cycle late
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 2'b00;
    end else begin
      err_q <= {lsu_store_err_i, lsu_load_err_i};
    end
  end

  ////////////////////
  // fault machines
  ////////////////////

  // same machine for both faults, both wait on the load stall
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      st_d[i] = st_q[i];
      req[i]  = 1'b0;
      case (st_q[i])
        FAULT_IDLE: begin
          if (err_q[i]) begin
            // raise now unless the lsu is still stalled
            if (load_stall_i) begin
              st_d[i] = FAULT_HELD;
            end else begin
              req[i]  = 1'b1;
              st_d[i] = FAULT_REQ;
            end
          end
        end
        FAULT_HELD: begin
          // release once the stall drops
          if (!load_stall_i) begin
            req[i]  = 1'b1;
            st_d[i] = FAULT_REQ;
          end
        end
        FAULT_REQ: begin
          req[i] = 1'b1;
        end
        default: begin
          st_d[i] = FAULT_IDLE;
        end
      endcase
      // ack wins over everything
      if (ack[i]) begin
        st_d[i] = FAULT_IDLE;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      st_q[0] <= FAULT_IDLE;
      st_q[1] <= FAULT_IDLE;
    end else begin
      st_q[0] <= st_d[0];
      st_q[1] <= st_d[1];
    end
  end

  assign load_fault_req_o  = req[0];
  assign store_fault_req_o = req[1];

endmodule

/* pc_cause_encoder.sv */
`timescale 1ns/1ps

module pc_cause_encoder (
  input  ctrl_pkg::ctrl_state_t ctrl_state_i,

  // id stage flags
  input  logic                  instr_valid_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  ecall_insn_i,
  input  logic                  illegal_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  ebrk_insn_i,
  input  logic                  csr_status_i,
  input  logic                  pipe_flush_i,

  // pending faults from the tracker
  input  logic                  load_fault_req_i,
  input  logic                  store_fault_req_i,

  input  ctrl_pkg::irq_id_t     irq_id_i,

  output logic                  flush_pending_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_sel_t     pc_mux_o,
  output ctrl_pkg::exc_pc_sel_t exc_pc_mux_o,
  output ctrl_pkg::exc_cause_t  exc_cause_o,
  output ctrl_pkg::exc_cause_t  csr_cause_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_save_cause_o,
  output logic                  csr_restore_mret_id_o,
  output logic                  load_fault_ack_o,
  output logic                  store_fault_ack_o
);

  import ctrl_pkg::*;

  logic insn_flush;
  logic jump_taken;

  // any insn flag that needs a pipeline flush
  assign insn_flush = ecall_insn_i | illegal_insn_i | mret_insn_i |
                      ebrk_insn_i | csr_status_i | pipe_flush_i;

  assign jump_taken = instr_valid_i & (branch_set_i | jump_set_i);

  // branches and jumps win over flushes in decode
  assign flush_pending_o = (ctrl_state_i == DECODE) & instr_valid_i & ~branch_set_i &
                           ~jump_set_i &
                           (insn_flush | load_fault_req_i | store_fault_req_i);

  ////////////////////
  // pc and cause
  ////////////////////

  always_comb begin
    pc_set_o              = 1'b0;
    pc_mux_o              = PC_BOOT;
    exc_pc_mux_o          = EXC_PC_IRQ;
    exc_cause_o           = '0;
    csr_cause_o           = '0;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_save_cause_o      = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    load_fault_ack_o      = 1'b0;
    store_fault_ack_o     = 1'b0;

    case (ctrl_state_i)
      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
      end

      DECODE: begin
        if (jump_taken) begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_JUMP;
        end
      end

      // msb of the cause marks an interrupt in the csr
      IRQ_TAKEN: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXCEPTION;
        exc_pc_mux_o     = EXC_PC_IRQ;
        exc_cause_o      = {1'b0, irq_id_i};
        csr_cause_o      = {1'b1, irq_id_i};
        csr_save_cause_o = 1'b1;
        csr_save_if_o    = 1'b1;
      end

      // reasons by priority, ecall first and store fault last
      FLUSH: begin
        if (ecall_insn_i) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_ECALL;
          exc_cause_o      = EXC_CAUSE_ECALL_MMODE;
          csr_cause_o      = EXC_CAUSE_ECALL_MMODE;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end else if (illegal_insn_i) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_ILLINSN;
          exc_cause_o      = EXC_CAUSE_ILLEGAL_INSN;
          csr_cause_o      = EXC_CAUSE_ILLEGAL_INSN;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
        end else if (mret_insn_i) begin
          // return from trap, restore mstatus
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_ERET;
          csr_restore_mret_id_o = 1'b1;
        end else if (ebrk_insn_i) begin
          // cause only, pc stays
          exc_cause_o = EXC_CAUSE_BREAKPOINT;
        end else if (csr_status_i || pipe_flush_i) begin
          // plain flush, nothing to redirect
          pc_set_o = 1'b0;
        end else if (load_fault_req_i) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXCEPTION;
          exc_pc_mux_o     = EXC_PC_LOAD;
          exc_cause_o      = EXC_CAUSE_LOAD_FAULT;
          csr_cause_o      = EXC_CAUSE_LOAD_FAULT;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          load_fault_ack_o = 1'b1;
        end else if (store_fault_req_i) begin
          pc_set_o          = 1'b1;
          pc_mux_o          = PC_EXCEPTION;
          exc_pc_mux_o      = EXC_PC_STORE;
          exc_cause_o       = EXC_CAUSE_STORE_FAULT;
          csr_cause_o       = EXC_CAUSE_STORE_FAULT;
          csr_save_id_o     = 1'b1;
          csr_save_cause_o  = 1'b1;
          store_fault_ack_o = 1'b1;
        end
      end

      default: begin
        pc_set_o = 1'b0;
      end
    endcase
  end

endmodule

/* sim.f */
ctrl_pkg.sv
lsu_fault_tracker.sv
ctrl_fsm.sv
pc_cause_encoder.sv
core_controller.sv
tb_clk_gen.sv
core_controller_props.sv
core_controller_tb.sv

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // free running clock, 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset low for 4 cycles, released away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
